//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs tb_simd_unit with Verilator, then checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
EXE=tb_simd_unit

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_simd_unit -f src.f \
        --Mdir "$BUILD_DIR" -o "$EXE"; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/$EXE" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -qx "all tests passed" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

//--- source/simd_completion_tracker.sv
`default_nettype none
`include "simd_consts.svh"

module simd_completion_tracker
    import simd_pkg::*;
(
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire simd_issue_t issue_i,
    output retire_sel_e      retire_sel_o,
    output exe_ctrl_t        retire_ctrl_o
);

    logic      is_mul;
    logic      is_mul64;
    exe_ctrl_t issue_ctrl;
    exe_ctrl_t alu_in;
    exe_ctrl_t mul_in;
    exe_ctrl_t mul64_in;
    exe_ctrl_t alu_taps   [`SIMD_LAT_ALU];
    exe_ctrl_t mul_taps   [`SIMD_LAT_MUL];
    exe_ctrl_t mul64_taps [`SIMD_LAT_MUL64];
    exe_ctrl_t alu_last;
    exe_ctrl_t mul_last;
    exe_ctrl_t mul64_last;

    assign is_mul   = (issue_i.op == OP_MUL);
    assign is_mul64 = is_mul && (issue_i.sew == SEW_64);

    always_comb begin
        issue_ctrl.valid    = issue_i.valid;
        issue_ctrl.op       = issue_i.op;
        issue_ctrl.sew      = issue_i.sew;
        issue_ctrl.use_mask = issue_i.use_mask;
        issue_ctrl.dest     = issue_i.dest;
        issue_ctrl.vs2      = issue_i.vs2;
        issue_ctrl.old_vd   = issue_i.old_vd;
        issue_ctrl.vm       = issue_i.vm;
        issue_ctrl.rs1      = issue_i.rs1;
    end

    // Only the matching latency class sees the instruction
    assign alu_in   = (issue_i.valid && !is_mul) ? issue_ctrl : '0;
    assign mul_in   = (issue_i.valid && is_mul && !is_mul64) ? issue_ctrl : '0;
    assign mul64_in = (issue_i.valid && is_mul64) ? issue_ctrl : '0;

    simd_delay_line #(.T(exe_ctrl_t), .DEPTH(`SIMD_LAT_ALU)) alu_line_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (alu_in),
        .taps_o (alu_taps)
    );

    simd_delay_line #(.T(exe_ctrl_t), .DEPTH(`SIMD_LAT_MUL)) mul_line_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (mul_in),
        .taps_o (mul_taps)
    );

    simd_delay_line #(.T(exe_ctrl_t), .DEPTH(`SIMD_LAT_MUL64)) mul64_line_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (mul64_in),
        .taps_o (mul64_taps)
    );

    assign alu_last   = alu_taps[`SIMD_LAT_ALU-1];
    assign mul_last   = mul_taps[`SIMD_LAT_MUL-1];
    assign mul64_last = mul64_taps[`SIMD_LAT_MUL64-1];

    // Longest latency wins if the issuer ever collides
    always_comb begin
        retire_sel_o  = RET_NONE;
        retire_ctrl_o = '0;
        if (mul64_last.valid) begin
            retire_sel_o  = RET_MUL64;
            retire_ctrl_o = mul64_last;
        end else if (mul_last.valid) begin
            retire_sel_o  = RET_MUL;
            retire_ctrl_o = mul_last;
        end else if (alu_last.valid) begin
            retire_sel_o  = RET_ALU;
            retire_ctrl_o = alu_last;
        end
    end

    a_no_retire_collision: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0({alu_last.valid, mul_last.valid, mul64_last.valid}));

    a_sel_none_when_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !retire_ctrl_o.valid |-> (retire_sel_o == RET_NONE));

endmodule

`default_nettype wire

//--- source/simd_consts.svh
`ifndef SIMD_CONSTS_SVH
`define SIMD_CONSTS_SVH

// Vector register geometry
`define SIMD_VLEN       128
`define SIMD_LANE_W     64
`define SIMD_LANES      2
`define SIMD_XLEN       64  // Scalar operand width

// Latency per class, in cycles from issue edge to writeback edge
`define SIMD_LAT_ALU    1
`define SIMD_LAT_MUL    2
`define SIMD_LAT_MUL64  3

// Field widths
`define SIMD_DEST_W     5
`define SIMD_MASK_W     16  // One bit per SEW_8 element
`define SIMD_OP_W       3
`define SIMD_SEW_W      2
`define SIMD_SRC_W      2

`endif

//--- source/simd_delay_line.sv
`default_nettype none

module simd_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  wire  clk_i,
    input  wire  rstn_i,
    input  wire  T in_i,
    output T     taps_o [DEPTH]
);

    // Tap k holds the input from k+1 cycles ago
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < DEPTH; k++) begin
                taps_o[k] <= '0;
            end
        end else begin
            taps_o[0] <= in_i;
            for (int k = 1; k < DEPTH; k++) begin
                taps_o[k] <= taps_o[k-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/simd_lane.sv
`default_nettype none
`include "simd_consts.svh"

module simd_lane
    import simd_pkg::*;
(
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire simd_issue_t issue_i,
    input  wire lane_word_t  vs1_i,
    input  wire lane_word_t  vs2_i,
    input  wire retire_sel_e retire_sel_i,
    output lane_word_t       result_o
);

    logic       is_sub;
    lane_word_t addsub;
    lane_word_t alu_d;
    lane_word_t alu_q;
    lane_word_t mul_d;
    lane_word_t mul_taps [`SIMD_LAT_MUL64];

    assign is_sub = (issue_i.op == OP_SUB);

    // Byte-sliced adder, the carry restarts at each element boundary
    always_comb begin
        lane_word_t opb;
        logic       carry;
        logic [8:0] byte_sum;
        opb   = is_sub ? ~vs1_i : vs1_i;
        carry = 1'b0;
        for (int j = 0; j < `SIMD_LANE_W/8; j++) begin
            if ((j % (1 << issue_i.sew)) == 0) begin
                carry = is_sub;  // +1 of two's complement
            end
            byte_sum = {1'b0, vs2_i[8*j +: 8]} + {1'b0, opb[8*j +: 8]} + {8'b0, carry};
            addsub[8*j +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    always_comb begin
        case (issue_i.op)
            OP_ADD, OP_SUB: alu_d = addsub;
            OP_AND:         alu_d = vs2_i & vs1_i;
            OP_OR:          alu_d = vs2_i | vs1_i;
            OP_XOR:         alu_d = vs2_i ^ vs1_i;
            default:        alu_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        alu_q <= alu_d;
    end

    // Low half of each element product
    always_comb begin
        mul_d = '0;
        case (issue_i.sew)
            SEW_8: begin
                for (int i = 0; i < `SIMD_LANE_W/8; i++) begin
                    mul_d[8*i +: 8] = vs2_i[8*i +: 8] * vs1_i[8*i +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < `SIMD_LANE_W/16; i++) begin
                    mul_d[16*i +: 16] = vs2_i[16*i +: 16] * vs1_i[16*i +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < `SIMD_LANE_W/32; i++) begin
                    mul_d[32*i +: 32] = vs2_i[32*i +: 32] * vs1_i[32*i +: 32];
                end
            end
            default: begin
                mul_d = vs2_i * vs1_i;
            end
        endcase
    end

    simd_delay_line #(
        .T     (lane_word_t),
        .DEPTH (`SIMD_LAT_MUL64)
    ) mul_pipe_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (mul_d),
        .taps_o (mul_taps)
    );

    always_comb begin
        case (retire_sel_i)
            RET_ALU:   result_o = alu_q;
            RET_MUL:   result_o = mul_taps[`SIMD_LAT_MUL-1];
            RET_MUL64: result_o = mul_taps[`SIMD_LAT_MUL64-1];
            default:   result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/simd_operand_expand.sv
`default_nettype none
`include "simd_consts.svh"

module simd_operand_expand
    import simd_pkg::*;
(
    input  wire simd_issue_t issue_i,
    output lane_words_t      vs1_lanes_o,
    output lane_words_t      vs2_lanes_o
);

    logic [`SIMD_XLEN-1:0] scalar_src;
    vreg_t                 replicated;
    vreg_t                 vs1_full;

    assign scalar_src = (issue_i.src_sel == SRC_VI) ? issue_i.imm : issue_i.rs1;

    // Broadcast the low SEW bits of the scalar to every element
    always_comb begin
        case (issue_i.sew)
            SEW_8: begin
                replicated = {(`SIMD_VLEN/8){scalar_src[7:0]}};
            end
            SEW_16: begin
                replicated = {(`SIMD_VLEN/16){scalar_src[15:0]}};
            end
            SEW_32: begin
                replicated = {(`SIMD_VLEN/32){scalar_src[31:0]}};
            end
            default: begin
                replicated = {(`SIMD_VLEN/64){scalar_src[63:0]}};
            end
        endcase
    end

    assign vs1_full = (issue_i.src_sel == SRC_VV) ? issue_i.vs1 : replicated;

    // Lane 0 takes the low word
    always_comb begin
        for (int l = 0; l < `SIMD_LANES; l++) begin
            vs1_lanes_o[l] = vs1_full[l*`SIMD_LANE_W +: `SIMD_LANE_W];
            vs2_lanes_o[l] = issue_i.vs2[l*`SIMD_LANE_W +: `SIMD_LANE_W];
        end
    end

endmodule

`default_nettype wire

//--- source/simd_pkg.sv
`default_nettype none
`include "simd_consts.svh"

package simd_pkg;

    typedef enum logic [`SIMD_SEW_W-1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    typedef enum logic [`SIMD_OP_W-1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_MV_X_S,  // vmv.x.s
        OP_EXT      // Extract element rs1
    } simd_op_e;

    typedef enum logic [`SIMD_SRC_W-1:0] {
        SRC_VV,
        SRC_VX,
        SRC_VI
    } src_sel_e;

    typedef logic [`SIMD_VLEN-1:0] vreg_t;
    typedef logic [`SIMD_LANE_W-1:0] lane_word_t;
    typedef lane_word_t [`SIMD_LANES-1:0] lane_words_t;

    typedef struct packed {
        logic                    valid;
        simd_op_e                op;
        sew_e                    sew;
        src_sel_e                src_sel;
        logic                    use_mask;
        logic [`SIMD_DEST_W-1:0] dest;
        vreg_t                   vs1;
        vreg_t                   vs2;
        vreg_t                   old_vd;
        logic [`SIMD_MASK_W-1:0] vm;
        logic [`SIMD_XLEN-1:0]   rs1;
        logic [`SIMD_XLEN-1:0]   imm;
    } simd_issue_t;

    // Fields needed at retirement
    typedef struct packed {
        logic                    valid;
        simd_op_e                op;
        sew_e                    sew;
        logic                    use_mask;
        logic [`SIMD_DEST_W-1:0] dest;
        vreg_t                   vs2;
        vreg_t                   old_vd;
        logic [`SIMD_MASK_W-1:0] vm;
        logic [`SIMD_XLEN-1:0]   rs1;
    } exe_ctrl_t;

    typedef enum logic [1:0] {
        RET_NONE,
        RET_ALU,
        RET_MUL,
        RET_MUL64
    } retire_sel_e;

    typedef struct packed {
        logic                    valid;
        logic [`SIMD_DEST_W-1:0] dest;
        vreg_t                   vresult;
    } simd_vec_wb_t;

    typedef struct packed {
        logic                    valid;
        logic [`SIMD_DEST_W-1:0] dest;
        logic [`SIMD_XLEN-1:0]   result;
    } simd_scalar_wb_t;

endpackage

`default_nettype wire

//--- source/simd_result_merge.sv
`default_nettype none
`include "simd_consts.svh"

module simd_result_merge
    import simd_pkg::*;
(
    input  wire exe_ctrl_t   retire_ctrl_i,
    input  wire lane_words_t lane_results_i,
    output simd_vec_wb_t     vec_wb_o,
    output simd_scalar_wb_t  scalar_wb_o
);

    localparam int IDX_W   = $clog2(`SIMD_VLEN/8);  // Index bits for SEW_8
    localparam int SHAMT_W = $clog2(`SIMD_VLEN);

    vreg_t                 lane_vec;
    vreg_t                 merged;
    vreg_t                 vs2_shift;
    lane_word_t            elem;
    logic [SHAMT_W-1:0]    shamt;
    logic                  in_range;
    logic                  is_scalar_op;
    logic [`SIMD_XLEN-1:0] sext;
    logic [`SIMD_XLEN-1:0] zext;

    assign lane_vec = lane_results_i;

    // Masked-off elements keep old vd, byte enables follow SEW
    always_comb begin
        for (int j = 0; j < `SIMD_VLEN/8; j++) begin
            if (!retire_ctrl_i.use_mask || retire_ctrl_i.vm[j >> retire_ctrl_i.sew]) begin
                merged[8*j +: 8] = lane_vec[8*j +: 8];
            end else begin
                merged[8*j +: 8] = retire_ctrl_i.old_vd[8*j +: 8];
            end
        end
    end

    // Element count is 2^(IDX_W - sew)
    assign in_range = ((retire_ctrl_i.rs1 >> (IDX_W - retire_ctrl_i.sew)) == '0);

    always_comb begin
        if (retire_ctrl_i.op == OP_EXT) begin
            shamt = {{(SHAMT_W-IDX_W){1'b0}}, retire_ctrl_i.rs1[IDX_W-1:0]}
                    << (3 + retire_ctrl_i.sew);
        end else begin
            shamt = '0;  // Element 0
        end
    end

    assign vs2_shift = retire_ctrl_i.vs2 >> shamt;
    assign elem      = vs2_shift[`SIMD_LANE_W-1:0];

    always_comb begin
        case (retire_ctrl_i.sew)
            SEW_8: begin
                sext = {{(`SIMD_XLEN-8){elem[7]}}, elem[7:0]};
                zext = {{(`SIMD_XLEN-8){1'b0}}, elem[7:0]};
            end
            SEW_16: begin
                sext = {{(`SIMD_XLEN-16){elem[15]}}, elem[15:0]};
                zext = {{(`SIMD_XLEN-16){1'b0}}, elem[15:0]};
            end
            SEW_32: begin
                sext = {{(`SIMD_XLEN-32){elem[31]}}, elem[31:0]};
                zext = {{(`SIMD_XLEN-32){1'b0}}, elem[31:0]};
            end
            default: begin
                sext = elem;
                zext = elem;
            end
        endcase
    end

    assign is_scalar_op = (retire_ctrl_i.op == OP_MV_X_S) || (retire_ctrl_i.op == OP_EXT);

    always_comb begin
        vec_wb_o.valid      = retire_ctrl_i.valid && !is_scalar_op;
        vec_wb_o.dest       = retire_ctrl_i.dest;
        vec_wb_o.vresult    = merged;
        scalar_wb_o.valid   = retire_ctrl_i.valid && is_scalar_op;
        scalar_wb_o.dest    = retire_ctrl_i.dest;
        if (retire_ctrl_i.op == OP_MV_X_S) begin
            scalar_wb_o.result = sext;
        end else begin
            scalar_wb_o.result = in_range ? zext : '0;  // Out of range reads as zero
        end
    end

    always_comb begin
        a_single_writeback: assert (!(vec_wb_o.valid && scalar_wb_o.valid));
    end

endmodule

`default_nettype wire

//--- source/simd_unit.sv
`default_nettype none
`include "simd_consts.svh"

module simd_unit
    import simd_pkg::*;
(
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire simd_issue_t issue_i,
    output simd_vec_wb_t     vec_wb_o,
    output simd_scalar_wb_t  scalar_wb_o
);

    lane_words_t      vs1_lanes;
    lane_words_t      vs2_lanes;
    wire lane_words_t lane_results;
    retire_sel_e      retire_sel;
    exe_ctrl_t        retire_ctrl;

    simd_operand_expand operand_expand_i (
        .issue_i     (issue_i),
        .vs1_lanes_o (vs1_lanes),
        .vs2_lanes_o (vs2_lanes)
    );

    simd_completion_tracker completion_tracker_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_i       (issue_i),
        .retire_sel_o  (retire_sel),
        .retire_ctrl_o (retire_ctrl)
    );

    for (genvar l = 0; l < `SIMD_LANES; l++) begin : g_lane
        simd_lane lane_i (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .issue_i      (issue_i),
            .vs1_i        (vs1_lanes[l]),
            .vs2_i        (vs2_lanes[l]),
            .retire_sel_i (retire_sel),
            .result_o     (lane_results[l])
        );
    end

    simd_result_merge result_merge_i (
        .retire_ctrl_i  (retire_ctrl),
        .lane_results_i (lane_results),
        .vec_wb_o       (vec_wb_o),
        .scalar_wb_o    (scalar_wb_o)
    );

endmodule

`default_nettype wire

//--- src.f
+incdir+source
+incdir+tb
source/simd_pkg.sv
source/simd_delay_line.sv
source/simd_operand_expand.sv
source/simd_lane.sv
source/simd_completion_tracker.sv
source/simd_result_merge.sv
source/simd_unit.sv
tb/tb_simd_unit.sv

//--- tb/simd_tb_model.svh
`ifndef SIMD_TB_MODEL_SVH
`define SIMD_TB_MODEL_SVH

function automatic logic [63:0] elem_mask(input sew_e sew);
    return (sew == SEW_64) ? '1 : ((64'd1 << (8 << sew)) - 64'd1);
endfunction

function automatic logic [63:0] get_elem(input vreg_t v, input sew_e sew, input int e);
    vreg_t sh;
    sh = v >> (e * (8 << sew));
    return sh[63:0] & elem_mask(sew);
endfunction

function automatic vreg_t put_elem(input vreg_t v, input sew_e sew, input int e,
                                   input logic [63:0] x);
    vreg_t m;
    m = vreg_t'(elem_mask(sew)) << (e * (8 << sew));
    return (v & ~m) | ((vreg_t'(x & elem_mask(sew)) << (e * (8 << sew))) & m);
endfunction

// Element-wise reference, each element wraps at its own width
function automatic vreg_t ref_alu(input simd_op_e op, input sew_e sew,
                                  input vreg_t vs2, input vreg_t vs1);
    vreg_t       res;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    res = '0;
    for (int e = 0; e < `SIMD_VLEN / (8 << sew); e++) begin
        a = get_elem(vs2, sew, e);
        b = get_elem(vs1, sew, e);
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_MUL:  r = a * b;
            default: r = '0;
        endcase
        res = put_elem(res, sew, e, r);
    end
    return res;
endfunction

function automatic vreg_t replicate_scalar(input sew_e sew, input logic [63:0] s);
    vreg_t res;
    res = '0;
    for (int e = 0; e < `SIMD_VLEN / (8 << sew); e++) begin
        res = put_elem(res, sew, e, s);
    end
    return res;
endfunction

function automatic vreg_t merge_masked(input sew_e sew, input logic [15:0] vm,
                                       input vreg_t newv, input vreg_t oldv);
    vreg_t res;
    res = '0;
    for (int e = 0; e < `SIMD_VLEN / (8 << sew); e++) begin
        res = put_elem(res, sew, e, vm[e] ? get_elem(newv, sew, e) : get_elem(oldv, sew, e));
    end
    return res;
endfunction

function automatic logic [63:0] move_to_scalar(input sew_e sew, input vreg_t vs2);
    logic [63:0] x;
    x = get_elem(vs2, sew, 0);
    if (sew != SEW_64 && x[(8 << sew) - 1]) begin
        x = x | ~elem_mask(sew);  // Sign extension
    end
    return x;
endfunction

function automatic logic [63:0] extract_elem(input sew_e sew, input vreg_t vs2,
                                             input logic [63:0] idx);
    if (idx >= 64'(`SIMD_VLEN / (8 << sew))) begin
        return '0;
    end
    return get_elem(vs2, sew, int'(idx));
endfunction

function automatic vreg_t rand_vreg();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
endfunction

function automatic simd_issue_t make_issue(input simd_op_e op, input sew_e sew,
                                           input src_sel_e src);
    simd_issue_t ins;
    ins          = '0;
    ins.valid    = 1'b1;
    ins.op       = op;
    ins.sew      = sew;
    ins.src_sel  = src;
    ins.dest     = 5'($random(seed));
    ins.vs1      = rand_vreg();
    ins.vs2      = rand_vreg();
    ins.old_vd   = rand_vreg();
    ins.rs1      = rand_word();
    ins.imm      = rand_word();
    return ins;
endfunction

task automatic idle_after_reset();
    int start;
    start = errors;
    repeat (4) begin
        @(negedge clk_i);
        check_val("vec_wb_o.valid", "idle after reset", 0, vec_wb_o.valid);
        check_val("scalar_wb_o.valid", "idle after reset", 0, scalar_wb_o.valid);
    end
    close_test("idle_after_reset", start);
endtask

task automatic vv_alu_ops();
    int          start;
    simd_issue_t ins;
    sew_e        sew;
    simd_op_e    op;
    start = errors;
    for (int s = 0; s < 4; s++) begin
        for (int o = 0; o <= 4; o++) begin
            sew = sew_e'(s);
            op  = simd_op_e'(o);
            ins = make_issue(op, sew, SRC_VV);
            send_issue(ins);
            expect_writeback(ins, ref_alu(op, sew, ins.vs2, ins.vs1),
                             $sformatf("vv %s sew%0d", op.name(), 8 << sew));
        end
    end
    close_test("vv_alu_ops", start);
endtask

task automatic vx_vi_add();
    int          start;
    simd_issue_t ins;
    sew_e        sew;
    src_sel_e    src;
    logic [63:0] scal;
    start = errors;
    for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 2; k++) begin
            sew  = sew_e'(s);
            src  = (k == 0) ? SRC_VX : SRC_VI;
            ins  = make_issue(OP_ADD, sew, src);
            scal = (src == SRC_VX) ? ins.rs1 : ins.imm;
            send_issue(ins);
            expect_writeback(ins, ref_alu(OP_ADD, sew, ins.vs2, replicate_scalar(sew, scal)),
                             $sformatf("%s add sew%0d", src.name(), 8 << sew));
        end
    end
    close_test("vx_vi_add", start);
endtask

// SEW 8 at edge N and SEW 64 at N+1 retire at N+2 and N+4
task automatic mul_overlap();
    int          start;
    simd_issue_t m8;
    simd_issue_t m64;
    bit          exp_valid;
    start = errors;
    m8  = make_issue(OP_MUL, SEW_8, SRC_VV);
    m64 = make_issue(OP_MUL, SEW_64, SRC_VV);
    @(posedge clk_i);
    issue_i <= m8;
    @(posedge clk_i);
    issue_i <= m64;
    @(posedge clk_i);
    issue_i <= '0;
    // Each negedge shows what the next edge N+k samples
    for (int k = 2; k <= 6; k++) begin
        @(negedge clk_i);
        exp_valid = (k == 2) || (k == 4);
        check_val("vec_wb_o.valid", $sformatf("mul overlap edge N+%0d", k),
                  exp_valid, vec_wb_o.valid);
        if (k == 2) begin
            check_val("vec_wb_o.vresult", "mul sew8",
                      ref_alu(OP_MUL, SEW_8, m8.vs2, m8.vs1), vec_wb_o.vresult);
            check_val("vec_wb_o.dest", "mul sew8", m8.dest, vec_wb_o.dest);
        end
        if (k == 4) begin
            check_val("vec_wb_o.vresult", "mul sew64",
                      ref_alu(OP_MUL, SEW_64, m64.vs2, m64.vs1), vec_wb_o.vresult);
            check_val("vec_wb_o.dest", "mul sew64", m64.dest, vec_wb_o.dest);
        end
        @(posedge clk_i);
    end
    close_test("mul_overlap", start);
endtask

task automatic masked_add();
    int          start;
    simd_issue_t ins;
    sew_e        sew;
    start = errors;
    for (int s = 0; s < 4; s++) begin
        sew          = sew_e'(s);
        ins          = make_issue(OP_ADD, sew, SRC_VV);
        ins.use_mask = 1'b1;
        ins.vm       = 16'($random(seed));
        send_issue(ins);
        expect_writeback(ins, merge_masked(sew, ins.vm, ref_alu(OP_ADD, sew, ins.vs2, ins.vs1),
                         ins.old_vd), $sformatf("masked add sew%0d", 8 << sew));
    end
    close_test("masked_add", start);
endtask

task automatic scalar_moves();
    int          start;
    int          n;
    simd_issue_t ins;
    sew_e        sew;
    start = errors;
    for (int s = 0; s < 4; s++) begin
        sew = sew_e'(s);
        n   = `SIMD_VLEN / (8 << sew);
        ins = make_issue(OP_MV_X_S, sew, SRC_VV);
        send_issue(ins);
        expect_writeback(ins, move_to_scalar(sew, ins.vs2), $sformatf("mv.x.s sew%0d", 8 << sew));
        ins     = make_issue(OP_EXT, sew, SRC_VV);
        ins.rs1 = {$random(seed)} % n;
        send_issue(ins);
        expect_writeback(ins, extract_elem(sew, ins.vs2, ins.rs1),
                         $sformatf("extract sew%0d idx %0d", 8 << sew, ins.rs1));
        ins     = make_issue(OP_EXT, sew, SRC_VV);
        ins.rs1 = n + ({$random(seed)} % 64);
        send_issue(ins);
        expect_writeback(ins, 0, $sformatf("extract sew%0d idx %0d", 8 << sew, ins.rs1));
    end
    close_test("scalar_moves", start);
endtask

`endif

//--- tb/tb_simd_unit.sv
`default_nettype none
`include "simd_consts.svh"

module tb_simd_unit
    import simd_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TESTS   = 6;
    localparam int WB_WAIT_MAX = 8;  // Cycles to wait for one writeback

    logic            clk_i = 1'b0;
    logic            rstn_i;
    simd_issue_t     issue_i;
    simd_vec_wb_t    vec_wb_o;
    simd_scalar_wb_t scalar_wb_o;

    integer seed         = 32'h44eb;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    simd_unit simd_unit_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .issue_i     (issue_i),
        .vec_wb_o    (vec_wb_o),
        .scalar_wb_o (scalar_wb_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic check_val(input string sig, input string ctx,
                             input logic [127:0] exp, input logic [127:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s (%s) expected %h got %h", $time, sig, ctx, exp, got);
            errors++;
        end
    endtask

    // Returns at the issue edge, the DUT samples ins on that edge
    task automatic send_issue(input simd_issue_t ins);
        @(posedge clk_i);
        issue_i <= ins;
        @(posedge clk_i);
        issue_i <= '0;
    endtask

    // Counts edges from the issue edge until the expected writeback shows up
    task automatic expect_writeback(input simd_issue_t ins, input vreg_t exp, input string ctx);
        int lat;
        int lat_exp;
        bit scalar;
        bit seen;
        scalar = (ins.op == OP_MV_X_S) || (ins.op == OP_EXT);
        if (ins.op == OP_MUL) begin
            lat_exp = (ins.sew == SEW_64) ? 3 : 2;
        end else begin
            lat_exp = 1;
        end
        lat  = 1;  // First negedge sees what edge N+1 samples
        seen = 1'b0;
        while (!seen && lat <= WB_WAIT_MAX) begin
            @(negedge clk_i);
            seen = scalar ? scalar_wb_o.valid : vec_wb_o.valid;
            if (!seen) begin
                @(posedge clk_i);
                lat++;
            end
        end
        assert (seen) else begin
            $display("ERROR at %0t: %s gave no writeback within %0d cycles", $time, ctx, WB_WAIT_MAX);
            errors++;
        end
        if (seen) begin
            check_val("writeback latency", ctx, lat_exp, lat);
            if (scalar) begin
                check_val("scalar_wb_o.result", ctx, exp, scalar_wb_o.result);
                check_val("scalar_wb_o.dest", ctx, ins.dest, scalar_wb_o.dest);
                check_val("vec_wb_o.valid", ctx, 0, vec_wb_o.valid);
            end else begin
                check_val("vec_wb_o.vresult", ctx, exp, vec_wb_o.vresult);
                check_val("vec_wb_o.dest", ctx, ins.dest, vec_wb_o.dest);
                check_val("scalar_wb_o.valid", ctx, 0, scalar_wb_o.valid);
            end
        end
    endtask

    task automatic close_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: FAILED with %0d errors", $time, name, errors - errs_at_start);
        end
    endtask

    `include "simd_tb_model.svh"

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles", NUM_TESTS * 200);
        $display("tests failed");
        $finish;
    end

    initial begin
        issue_i = '0;
        rstn_i  = 1'b0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        idle_after_reset();
        vv_alu_ops();
        vx_vi_add();
        mul_overlap();
        masked_add();
        scalar_moves();

        $display("Summary: %0d run, %0d failing, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
